// File: all.f
src/z80_bus_pkg.sv
src/cycle_sequencer.sv
src/acc_pc_datapath.sv
src/bus_strobes.sv
src/tiny_z80.sv
dv/bus_memory_model.sv
dv/tb_tiny_z80.sv

// File: dv/bus_memory_model.sv
// Testbench bus model with 64 KB of memory and 256 I/O ports on the Z80-style bus
// Adds 0 to 3 random wait states per access and logs every memory and I/O write
`timescale 1ns/1ns

module bus_memory_model
  import z80_bus_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  logic [addr_w-1:0] addr,
  input  logic [data_w-1:0] dout,
  input  logic              mreq_n,
  input  logic              iorq_n,
  input  logic              rd_n,
  input  logic              wr_n,
  output logic              wait_n,
  output logic [data_w-1:0] di
);

  logic [data_w-1:0] mem [0:65535];
  logic [data_w-1:0] io_space [0:255];
  // Write logs, read back by the testbench once the program has halted
  logic [addr_w-1:0] mem_wr_addr [0:7];
  logic [data_w-1:0] mem_wr_data [0:7];
  logic [7:0]        io_wr_port [0:7];
  logic [data_w-1:0] io_wr_data [0:7];
  int                mem_wr_count;
  int                io_wr_count;
  // Accesses with both or neither of mreq_n and iorq_n, or both of rd_n and wr_n
  int                bad_strobe_count;
  logic [31:0]       lcg_state;
  logic              in_access;
  int                wait_left;
  logic              active;

  assign active = !rd_n || !wr_n;

  // Linear congruential generator for the wait state counts
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  initial
  begin
    lcg_state        = 32'ha638_b628;
    wait_n           = 1'b1;
    di               = '0;
    in_access        = 1'b0;
    wait_left        = 0;
    mem_wr_count     = 0;
    io_wr_count      = 0;
    bad_strobe_count = 0;
  end

  // Responses change on the falling edge and the core samples them on the rising edge
  always @(negedge clk)
  begin
    if (!reset_n)
    begin
      in_access        = 1'b0;
      wait_left        = 0;
      mem_wr_count     = 0;
      io_wr_count      = 0;
      bad_strobe_count = 0;
      wait_n <= 1'b1;
    end
    else if (active)
    begin
      if (!in_access)
      begin
        // A new access draws its wait count from the upper LCG bits
        in_access = 1'b1;
        lcg_state = lcg_next(lcg_state);
        wait_left = lcg_state[31:30];
        if (mreq_n == iorq_n || rd_n == wr_n)
          bad_strobe_count++;
        if (!rd_n)
          di <= !mreq_n ? mem[addr] : io_space[addr[7:0]];
      end
      if (wait_left > 0)
      begin
        wait_n <= 1'b0;
        wait_left--;
      end
      else
      begin
        // Last clock of T2, the access completes on the next rising edge
        wait_n <= 1'b1;
        if (!wr_n && !mreq_n && iorq_n)
        begin
          mem[addr] = dout;
          if (mem_wr_count < 8)
          begin
            mem_wr_addr[mem_wr_count] = addr;
            mem_wr_data[mem_wr_count] = dout;
          end
          mem_wr_count++;
        end
        else if (!wr_n && !iorq_n && mreq_n)
        begin
          if (io_wr_count < 8)
          begin
            io_wr_port[io_wr_count] = addr[7:0];
            io_wr_data[io_wr_count] = dout;
          end
          io_wr_count++;
        end
      end
    end
    else
    begin
      in_access = 1'b0;
      wait_n <= 1'b1;
    end
  end

endmodule

// File: dv/tb_tiny_z80.sv
// Testbench for the small Z80-style core
// Runs a table of short programs through the bus model and checks the logged writes
`timescale 1ns/1ns

module tb_tiny_z80
  import z80_bus_pkg::*;
();

  localparam int n_tests = 6;
  // Covers reset, the longest program with every access stretched, and the halt check
  localparam int cycle_limit = n_tests * 200;

  logic              clk;
  logic              reset_n;
  logic              wait_n;
  logic [data_w-1:0] di;
  logic [addr_w-1:0] addr;
  logic [data_w-1:0] dout;
  logic              mreq_n;
  logic              iorq_n;
  logic              rd_n;
  logic              wr_n;
  logic              halt_n;

  int   cycle_count;
  int   test_idx;
  logic stretched;
  logic halt_seen;
  logic mem_read_prev;

  // Stimulus table, each program is 16 bytes with the first byte on the left
  logic [127:0]      prog_tbl     [0:n_tests-1];
  logic              exp_mem_v    [0:n_tests-1];
  logic [addr_w-1:0] exp_mem_addr [0:n_tests-1];
  logic [data_w-1:0] exp_mem_data [0:n_tests-1];
  logic              exp_io_v     [0:n_tests-1];
  logic [7:0]        exp_io_port  [0:n_tests-1];
  logic [data_w-1:0] exp_io_data  [0:n_tests-1];
  logic [7:0]        in_port      [0:n_tests-1];
  logic [data_w-1:0] in_value     [0:n_tests-1];
  logic [addr_w-1:0] pre_addr     [0:n_tests-1];
  logic [data_w-1:0] pre_data     [0:n_tests-1];

  tiny_z80 #(
    .t2_write (1'b1)
  ) u_tiny_z80 (
    .clk     (clk),
    .reset_n (reset_n),
    .wait_n  (wait_n),
    .di      (di),
    .addr    (addr),
    .dout    (dout),
    .mreq_n  (mreq_n),
    .iorq_n  (iorq_n),
    .rd_n    (rd_n),
    .wr_n    (wr_n),
    .halt_n  (halt_n)
  );

  bus_memory_model u_bus_memory_model (
    .clk     (clk),
    .reset_n (reset_n),
    .addr    (addr),
    .dout    (dout),
    .mreq_n  (mreq_n),
    .iorq_n  (iorq_n),
    .rd_n    (rd_n),
    .wr_n    (wr_n),
    .wait_n  (wait_n),
    .di      (di)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Z80 result of an accumulator immediate opcode, as in the instruction set manual
  function automatic logic [7:0] apply_immediate(input logic [7:0] opc, input logic [7:0] a,
                                                 input logic [7:0] n);
    case (opc)
      8'h3E:   return n;
      8'hC6:   return a + n;
      8'hD6:   return a - n;
      8'hE6:   return a & n;
      8'hF6:   return a | n;
      8'hEE:   return a ^ n;
      default: return a;
    endcase
  endfunction

  // Background memory contents, every address bit takes part
  function automatic logic [7:0] fill_byte(input logic [15:0] a);
    return a[15:8] ^ {a[6:0], a[7]} ^ 8'hA5;
  endfunction

  task automatic set_entry(input int t, input logic [127:0] prog,
                           input logic mv, input logic [15:0] maddr, input logic [7:0] mdata,
                           input logic iov, input logic [7:0] port, input logic [7:0] iodata,
                           input logic [7:0] inp, input logic [7:0] inv,
                           input logic [15:0] paddr, input logic [7:0] pdata);
    prog_tbl[t]     = prog;
    exp_mem_v[t]    = mv;
    exp_mem_addr[t] = maddr;
    exp_mem_data[t] = mdata;
    exp_io_v[t]     = iov;
    exp_io_port[t]  = port;
    exp_io_data[t]  = iodata;
    in_port[t]      = inp;
    in_value[t]     = inv;
    pre_addr[t]     = paddr;
    pre_data[t]     = pdata;
  endtask

  task automatic build_table();
    logic [7:0] acc;
    // LD A,5A then LD (1234),A
    set_entry(0, 128'h3E5A_3234_1276_0000_0000_0000_0000_0000,
              1'b1, 16'h1234, 8'h5A, 1'b0, 8'h00, 8'h00, 8'h00, 8'h00, 16'h8000, 8'h00);
    // Chain of all five ALU immediates, result stored at 2000
    acc = apply_immediate(8'h3E, 8'h00, 8'h9C);
    acc = apply_immediate(8'hC6, acc, 8'h7B);
    acc = apply_immediate(8'hD6, acc, 8'h30);
    acc = apply_immediate(8'hE6, acc, 8'hF3);
    acc = apply_immediate(8'hF6, acc, 8'h05);
    acc = apply_immediate(8'hEE, acc, 8'hA5);
    set_entry(1, 128'h3E9C_C67B_D630_E6F3_F605_EEA5_3200_2076,
              1'b1, 16'h2000, acc, 1'b0, 8'h00, 8'h00, 8'h00, 8'h00, 16'h8000, 8'h00);
    // LD A,(4321) then OUT (55),A copies the preloaded byte to the port
    set_entry(2, 128'h3A21_43D3_5576_0000_0000_0000_0000_0000,
              1'b0, 16'h0000, 8'h00, 1'b1, 8'h55, 8'hC7, 8'h00, 8'h00, 16'h4321, 8'hC7);
    // IN A,(81) then LD (3000),A stores the byte the port returns
    set_entry(3, 128'hDB81_3200_3076_0000_0000_0000_0000_0000,
              1'b1, 16'h3000, 8'h3D, 1'b0, 8'h00, 8'h00, 8'h81, 8'h3D, 16'h8000, 8'h00);
    // JP 000A skips the store to 5000, only the store to 5100 happens
    set_entry(4, 128'h3E11_C30A_0032_0050_7600_3E22_3200_5176,
              1'b1, 16'h5100, 8'h22, 1'b0, 8'h00, 8'h00, 8'h00, 8'h00, 16'h8000, 8'h00);
    // NOP and an unsupported opcode, then an ADD with carry out to both port and memory
    acc = apply_immediate(8'hC6, apply_immediate(8'h3E, 8'h00, 8'hF0), 8'h20);
    set_entry(5, 128'h0007_3EF0_C620_D312_3200_0876_0000_0000,
              1'b1, 16'h0800, acc, 1'b1, 8'h12, acc, 8'h00, 8'h00, 16'h8000, 8'h00);
  endtask

  task automatic run_program(input int t);
    logic [127:0] prog;
    int           a;
    prog = prog_tbl[t];
    @(negedge clk);
    reset_n = 1'b0;
    for (a = 0; a < 65536; a++)
      u_bus_memory_model.mem[a] = fill_byte(a[15:0]);
    for (a = 0; a < 256; a++)
      u_bus_memory_model.io_space[a] = a[7:0] ^ 8'h3C;
    for (a = 0; a < 16; a++)
      u_bus_memory_model.mem[a] = prog[127 - 8*a -: 8];
    u_bus_memory_model.mem[pre_addr[t]]     = pre_data[t];
    u_bus_memory_model.io_space[in_port[t]] = in_value[t];
    repeat (10) @(negedge clk);
    check_value("halt_n after reset", halt_n, 1'b1);
    check_value("{mreq_n,iorq_n,rd_n,wr_n} after reset", {mreq_n, iorq_n, rd_n, wr_n}, 4'hF);
    reset_n = 1'b1;
    while (halt_n !== 1'b0)
      @(negedge clk);
    // Stay halted a while so the monitor can see a quiet bus
    repeat (20) @(negedge clk);
    check_value("bad strobe combinations", u_bus_memory_model.bad_strobe_count, 0);
    check_value("memory write count", u_bus_memory_model.mem_wr_count, exp_mem_v[t]);
    if (exp_mem_v[t])
    begin
      check_value("addr (memory write)", u_bus_memory_model.mem_wr_addr[0], exp_mem_addr[t]);
      check_value("dout (memory write)", u_bus_memory_model.mem_wr_data[0], exp_mem_data[t]);
    end
    check_value("I/O write count", u_bus_memory_model.io_wr_count, exp_io_v[t]);
    if (exp_io_v[t])
    begin
      check_value("addr port (I/O write)", u_bus_memory_model.io_wr_port[0], exp_io_port[t]);
      check_value("dout (I/O write)", u_bus_memory_model.io_wr_data[0], exp_io_data[t]);
    end
  endtask

  // Bus monitor, sampling the registered strobes on the rising edge
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count > cycle_limit)
    begin
      $display("Timeout: the programs did not all halt within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $fatal(1, "Run stopped by the cycle limit");
    end
    else if (!reset_n)
    begin
      stretched     = 1'b0;
      halt_seen     = 1'b0;
      mem_read_prev = 1'b0;
    end
    else
    begin
      // A strobe seen with wait_n low must still be low one clock later
      if (stretched)
        check_value("rd_n & wr_n during wait", rd_n & wr_n, 1'b0);
      if (halt_seen)
      begin
        check_value("halt_n while halted", halt_n, 1'b0);
        check_value("{mreq_n,iorq_n,rd_n,wr_n} while halted",
                    {mreq_n, iorq_n, rd_n, wr_n}, 4'hF);
      end
      // A lone memory request only trails a memory read, as in T3 of a fetch
      if (!mreq_n && rd_n && wr_n)
        check_value("mreq_n after memory read", mem_read_prev, 1'b1);
      stretched     = (!rd_n || !wr_n) && !wait_n;
      halt_seen     = halt_seen || !halt_n;
      mem_read_prev = !mreq_n && !rd_n;
    end
  end

  initial
  begin
    reset_n       = 1'b0;
    cycle_count   = 0;
    stretched     = 1'b0;
    halt_seen     = 1'b0;
    mem_read_prev = 1'b0;
    build_table();
    for (test_idx = 0; test_idx < n_tests; test_idx++)
      run_program(test_idx);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: src/acc_pc_datapath.sv
// Accumulator, program counter, operand latch and ALU of the core
// Driven by the sequencer controls, it forms the bus address and write data
`timescale 1ns/1ns

module acc_pc_datapath
  import z80_bus_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  logic [data_w-1:0] read_data,
  input  logic              load_ir,
  input  logic              load_lo,
  input  logic              load_hi,
  input  logic              load_acc,
  input  logic              pc_inc,
  input  logic              pc_load,
  input  logic [1:0]        addr_sel,
  input  alu_op_e           alu_op,
  output opcode_e           ir,
  output logic [addr_w-1:0] addr,
  output logic [data_w-1:0] dout,
  output logic              carry,
  output logic              zero
);

  logic [addr_w-1:0] pc_q;
  logic [data_w-1:0] lo_q;
  logic [data_w-1:0] hi_q;
  logic [data_w-1:0] acc_q;
  // Bit 8 is the carry or borrow out of the ALU
  logic [data_w:0]   alu_res;

  // ALU with Z80 8-bit semantics for the immediate group
  always_comb
  begin
    case (alu_op)
      alu_add: alu_res = {1'b0, acc_q} + {1'b0, read_data};
      alu_sub: alu_res = {1'b0, acc_q} - {1'b0, read_data};
      // Logic operations clear carry
      alu_and: alu_res = {1'b0, acc_q & read_data};
      alu_or:  alu_res = {1'b0, acc_q | read_data};
      alu_xor: alu_res = {1'b0, acc_q ^ read_data};
      default: alu_res = {carry, read_data};
    endcase
  end

  // Program counter, accumulator and flags
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      pc_q  <= '0;
      acc_q <= '0;
      carry <= 1'b0;
      zero  <= 1'b0;
    end
    else
    begin
      // JP takes the high byte as it arrives and the low byte from the latch
      if (pc_load)
        pc_q <= {read_data, lo_q};
      else if (pc_inc)
        pc_q <= pc_q + addr_w'(1);

      if (load_acc)
      begin
        acc_q <= alu_res[data_w-1:0];
        // Plain loads and IN leave the flags alone
        if (alu_op != alu_pass)
        begin
          carry <= alu_res[data_w];
          zero  <= (alu_res[data_w-1:0] == '0);
        end
      end
    end
  end

  // Opcode and operand bytes are always written before they are used
  always_ff @(posedge clk)
  begin
    if (load_ir)
      ir <= opcode_e'(read_data);
    if (load_lo)
      lo_q <= read_data;
    if (load_hi)
      hi_q <= read_data;
  end

  // Address source, held for the whole machine cycle
  always_comb
  begin
    case (addr_sel)
      addr_sel_latch: addr = {hi_q, lo_q};
      // The port number appears on both halves of the bus
      addr_sel_io:    addr = {lo_q, lo_q};
      default:        addr = pc_q;
    endcase
  end

  // Only A is ever stored, so the write data is the accumulator
  assign dout = acc_q;

endmodule

// File: src/bus_strobes.sv
// Registered Z80 bus strobes and the read data latch
// Strobes follow the cycle kind and T-state from the sequencer and honour wait_n
`timescale 1ns/1ns

module bus_strobes
  import z80_bus_pkg::*;
#(
  parameter bit t2_write = 1'b1
)
(
  input  logic              clk,
  input  logic              reset_n,
  input  mcycle_e           mcycle,
  input  tstate_e           tstate,
  input  logic              wait_n,
  input  logic [data_w-1:0] di,
  output logic              mreq_n,
  output logic              iorq_n,
  output logic              rd_n,
  output logic              wr_n,
  output logic [data_w-1:0] read_data
);

  logic access_phase;
  logic write_phase;

  // Sampled in T1 and in every stretched T2, so the strobe is low
  // through T2 and all of its wait states
  assign access_phase = (tstate == t1) || (tstate == t2 && !wait_n);

  // With t2_write clear the write strobe is sampled from T2 and
  // goes low one clock later, after the data has settled
  assign write_phase = t2_write ? access_phase : (tstate == t2);

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      mreq_n <= 1'b1;
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      wr_n   <= 1'b1;
    end
    else
    begin
      // Strobes are inactive unless the cycle below asks for them
      mreq_n <= 1'b1;
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      wr_n   <= 1'b1;
      case (mcycle)
        m_fetch:
        begin
          if (access_phase)
          begin
            mreq_n <= 1'b0;
            rd_n   <= 1'b0;
          end
          // Memory request also covers T3 of the fetch
          if (tstate == t2)
            mreq_n <= 1'b0;
        end
        m_read_op, m_mem_read:
        begin
          if (access_phase)
          begin
            mreq_n <= 1'b0;
            rd_n   <= 1'b0;
          end
        end
        m_io_read:
        begin
          if (access_phase)
          begin
            iorq_n <= 1'b0;
            rd_n   <= 1'b0;
          end
        end
        m_mem_write:
        begin
          if (write_phase)
          begin
            mreq_n <= 1'b0;
            wr_n   <= 1'b0;
          end
        end
        m_io_write:
        begin
          if (write_phase)
          begin
            iorq_n <= 1'b0;
            wr_n   <= 1'b0;
          end
        end
        default:
        begin
          // Idle while halted, no bus activity
        end
      endcase
    end
  end

  // Input data is taken on the edge that ends T2
  always_ff @(posedge clk)
  begin
    if (tstate == t2 && wait_n)
      read_data <= di;
  end

endmodule

// File: src/cycle_sequencer.sv
// Control FSM of the core: steps M-cycles and T-states and decodes the opcode
// The datapath and the bus strobe block follow the controls it produces
`timescale 1ns/1ns

module cycle_sequencer
  import z80_bus_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       wait_n,
  input  opcode_e    ir,
  output mcycle_e    mcycle,
  output tstate_e    tstate,
  output logic       load_ir,
  output logic       load_lo,
  output logic       load_hi,
  output logic       load_acc,
  output logic       pc_inc,
  output logic       pc_load,
  output logic [1:0] addr_sel,
  output alu_op_e    alu_op,
  output logic       halt_n
);

  // Index of the current M-cycle within the instruction, fetch is 1
  logic [2:0] mindex;
  logic [2:0] next_index;
  mcycle_e    next_kind;
  logic       last_t;
  logic       op_read_end;
  logic       is_acc_imm;
  logic       is_addr_op;
  logic       is_long_addr;

  // Opcode groups used by the decoder
  assign is_acc_imm   = ir inside {op_ld_a_n, op_add_n, op_sub_n, op_and_n, op_or_n, op_xor_n};
  assign is_addr_op   = ir inside {op_out_n_a, op_in_a_n, op_jp_nn, op_ld_nn_a, op_ld_a_nn};
  assign is_long_addr = ir inside {op_jp_nn, op_ld_nn_a, op_ld_a_nn};

  // The fetch cycle ends in T4, all other cycles end in T3
  assign last_t = (mcycle == m_fetch) ? (tstate == t4) : (tstate == t3);

  // Final T-state of an operand read, where the latched byte is consumed
  assign op_read_end = (mcycle == m_read_op) && (tstate == t3);

  // Pick the next cycle kind from the opcode and the cycle index
  always_comb
  begin
    next_kind = m_fetch;
    case (mindex)
      3'd1:
      begin
        if (ir == op_halt)
          next_kind = m_idle;
        else if (is_acc_imm || is_addr_op)
          next_kind = m_read_op;
      end
      3'd2:
      begin
        if (ir == op_out_n_a)
          next_kind = m_io_write;
        else if (ir == op_in_a_n)
          next_kind = m_io_read;
        else if (is_long_addr)
          next_kind = m_read_op;
      end
      3'd3:
      begin
        if (ir == op_ld_nn_a)
          next_kind = m_mem_write;
        else if (ir == op_ld_a_nn)
          next_kind = m_mem_read;
      end
      default:
        next_kind = m_fetch;
    endcase
  end

  // A new instruction always restarts the index at 1
  assign next_index = (next_kind == m_fetch) ? 3'd1 : mindex + 3'd1;

  // Cycle and T-state registers
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      mcycle <= m_fetch;
      tstate <= t1;
      mindex <= 3'd1;
    end
    else if (mcycle != m_idle)
    begin
      if (last_t)
      begin
        mcycle <= next_kind;
        mindex <= next_index;
        tstate <= t1;
      end
      else
      begin
        case (tstate)
          t1: tstate <= t2;
          // Memory or I/O holds the cycle here with wait_n low
          t2: if (wait_n) tstate <= t3;
          t3: tstate <= t4;
          default: tstate <= t1;
        endcase
      end
    end
  end

  // The opcode byte is latched at the end of T2, so it is moved into ir in T3
  // and is decoded at the end of T4
  assign load_ir = (mcycle == m_fetch) && (tstate == t3);

  // PC advances past the opcode and past each operand byte
  // The high byte of JP goes straight into the PC instead
  assign pc_inc = ((mcycle == m_fetch) && (tstate == t4)) ||
                  (op_read_end && !(ir == op_jp_nn && mindex == 3'd3));
  assign pc_load = op_read_end && (ir == op_jp_nn) && (mindex == 3'd3);

  // Operand bytes that form a port or memory address
  assign load_lo = op_read_end && (mindex == 3'd2) && is_addr_op;
  assign load_hi = op_read_end && (mindex == 3'd3) && is_long_addr;

  // Accumulator takes an immediate result, a memory byte or an I/O byte
  assign load_acc = (op_read_end && (mindex == 3'd2) && is_acc_imm) ||
                    (mcycle == m_mem_read && tstate == t3) ||
                    (mcycle == m_io_read && tstate == t3);

  // ALU function from the opcode, loads and IN pass the byte through
  always_comb
  begin
    case (ir)
      op_add_n: alu_op = alu_add;
      op_sub_n: alu_op = alu_sub;
      op_and_n: alu_op = alu_and;
      op_or_n:  alu_op = alu_or;
      op_xor_n: alu_op = alu_xor;
      default:  alu_op = alu_pass;
    endcase
  end

  // Address source for the whole cycle
  always_comb
  begin
    case (mcycle)
      m_mem_read, m_mem_write: addr_sel = addr_sel_latch;
      m_io_read, m_io_write:   addr_sel = addr_sel_io;
      default:                 addr_sel = addr_sel_pc;
    endcase
  end

  // Halted once the idle cycle is entered, left only by reset
  assign halt_n = (mcycle != m_idle);

endmodule

// File: src/tiny_z80.sv
// Top level of the small Z80-style core with its external bus
// Connects the sequencer, the datapath and the bus strobes
`timescale 1ns/1ns

module tiny_z80
  import z80_bus_pkg::*;
#(
  // Selects write strobe timing in the bus strobe block
  parameter bit t2_write = 1'b1
)
(
  input  logic              clk,
  input  logic              reset_n,
  input  logic              wait_n,
  input  logic [data_w-1:0] di,
  output logic [addr_w-1:0] addr,
  output logic [data_w-1:0] dout,
  output logic              mreq_n,
  output logic              iorq_n,
  output logic              rd_n,
  output logic              wr_n,
  output logic              halt_n
);

  // Sequencer to datapath
  opcode_e           ir;
  logic              load_ir;
  logic              load_lo;
  logic              load_hi;
  logic              load_acc;
  logic              pc_inc;
  logic              pc_load;
  logic [1:0]        addr_sel;
  alu_op_e           alu_op;

  // Sequencer to bus strobes and the latched input byte back
  mcycle_e           mcycle;
  tstate_e           tstate;
  logic [data_w-1:0] read_data;

  cycle_sequencer u_cycle_sequencer (
    .clk      (clk),
    .reset_n  (reset_n),
    .wait_n   (wait_n),
    .ir       (ir),
    .mcycle   (mcycle),
    .tstate   (tstate),
    .load_ir  (load_ir),
    .load_lo  (load_lo),
    .load_hi  (load_hi),
    .load_acc (load_acc),
    .pc_inc   (pc_inc),
    .pc_load  (pc_load),
    .addr_sel (addr_sel),
    .alu_op   (alu_op),
    .halt_n   (halt_n)
  );

  // Flags are kept internal, no opcode in the subset branches on them
  acc_pc_datapath u_acc_pc_datapath (
    .clk       (clk),
    .reset_n   (reset_n),
    .read_data (read_data),
    .load_ir   (load_ir),
    .load_lo   (load_lo),
    .load_hi   (load_hi),
    .load_acc  (load_acc),
    .pc_inc    (pc_inc),
    .pc_load   (pc_load),
    .addr_sel  (addr_sel),
    .alu_op    (alu_op),
    .ir        (ir),
    .addr      (addr),
    .dout      (dout),
    .carry     (),
    .zero      ()
  );

  bus_strobes #(
    .t2_write (t2_write)
  ) u_bus_strobes (
    .clk       (clk),
    .reset_n   (reset_n),
    .mcycle    (mcycle),
    .tstate    (tstate),
    .wait_n    (wait_n),
    .di        (di),
    .mreq_n    (mreq_n),
    .iorq_n    (iorq_n),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .read_data (read_data)
  );

endmodule

// File: src/z80_bus_pkg.sv
// Shared types and bus widths for the small Z80-style core
// Imported by every RTL block and by the testbench bus model
package z80_bus_pkg;

  // Address and data bus widths
  localparam int addr_w = 16;
  localparam int data_w = 8;

  // Address source select from the sequencer to the datapath
  localparam logic [1:0] addr_sel_pc    = 2'd0;
  localparam logic [1:0] addr_sel_latch = 2'd1;
  localparam logic [1:0] addr_sel_io    = 2'd2;

  // Supported opcodes with their Z80 encodings
  // Every other byte is run as a NOP
  typedef enum logic [7:0] {
    op_nop     = 8'h00,
    op_ld_a_n  = 8'h3E,
    op_add_n   = 8'hC6,
    op_sub_n   = 8'hD6,
    op_and_n   = 8'hE6,
    op_or_n    = 8'hF6,
    op_xor_n   = 8'hEE,
    op_ld_nn_a = 8'h32,
    op_ld_a_nn = 8'h3A,
    op_out_n_a = 8'hD3,
    op_in_a_n  = 8'hDB,
    op_jp_nn   = 8'hC3,
    op_halt    = 8'h76
  } opcode_e;

  // Kind of machine cycle in progress
  typedef enum logic [2:0] {
    m_fetch,
    m_read_op,
    m_mem_read,
    m_mem_write,
    m_io_read,
    m_io_write,
    m_idle
  } mcycle_e;

  // T-state within a machine cycle
  typedef enum logic [2:0] {
    t1 = 3'd1,
    t2 = 3'd2,
    t3 = 3'd3,
    t4 = 3'd4
  } tstate_e;

  // Operation applied to the accumulator and the read byte
  typedef enum logic [2:0] {
    alu_pass,
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor
  } alu_op_e;

endpackage
